// File: rtl/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] strb_t;

    // AXI response encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // Write address and data travel in one request beat
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t wstrb;
    } xbar_req_t;

    typedef struct packed {
        data_t rdata;
        resp_t resp;
    } xbar_rsp_t;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

// File: rtl/axi_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module axi_addr_decode #(
    parameter int N_SLV = 2,
    parameter logic [N_SLV*axi_xbar_pkg::ADDR_W-1:0] SLV_START = '0,
    parameter logic [N_SLV*axi_xbar_pkg::ADDR_W-1:0] SLV_END = '0
) (
    input  axi_xbar_pkg::addr_t i_addr,
    output logic [N_SLV-1:0]    o_slv_sel,
    output logic                o_dec_err
);

    localparam int AW = axi_xbar_pkg::ADDR_W;

    // Inclusive window compare per slave
    always_comb begin
        o_slv_sel = '0;
        for (int s = 0; s < N_SLV; s++) begin
            if ((i_addr >= SLV_START[s*AW +: AW]) && (i_addr <= SLV_END[s*AW +: AW])) begin
                o_slv_sel[s] = 1'b1;
            end
        end
    end

    // Unmapped address goes to the error responder
    assign o_dec_err = ~|o_slv_sel;

    // Overlapping windows in the map would select two slaves at once
    always_comb begin
        assert final ($onehot0(o_slv_sel))
            else $error("address %h matches more than one slave window", i_addr);
    end

endmodule

`default_nettype wire

// File: rtl/axi_xbar_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module axi_xbar_arbiter #(
    parameter int N_MST = 2
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [N_MST-1:0] i_req,
    input  logic             i_done,
    output logic [N_MST-1:0] o_grant,
    output logic             o_busy
);

    localparam int PTR_W = (N_MST > 1) ? $clog2(N_MST) : 1;

    axi_xbar_pkg::arb_state_t state;
    logic [N_MST-1:0]         grant_q;
    logic [N_MST-1:0]         grant_next;
    logic [PTR_W-1:0]         ptr;
    logic [PTR_W-1:0]         served;
    logic [PTR_W-1:0]         ptr_next;

    // First requester at or after the pointer
    always_comb begin : pick
        int   idx;
        logic found;
        grant_next = '0;
        found = 1'b0;
        for (int k = 0; k < N_MST; k++) begin
            idx = (int'(ptr) + k) % N_MST;
            if (!found && i_req[idx]) begin
                grant_next[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        served = '0;
        for (int m = 0; m < N_MST; m++) begin
            if (grant_q[m]) begin
                served = PTR_W'(m);
            end
        end
    end

    assign ptr_next = (served == PTR_W'(N_MST-1)) ? '0 : served + 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= axi_xbar_pkg::IDLE;
            grant_q <= '0;
            ptr <= '0;
        end else begin
            case (state)
                axi_xbar_pkg::IDLE: begin
                    if (|i_req) begin
                        grant_q <= grant_next;
                        state <= axi_xbar_pkg::BUSY;
                    end
                end
                axi_xbar_pkg::BUSY: begin
                    // Held until the response handshake
                    if (i_done) begin
                        grant_q <= '0;
                        ptr <= ptr_next;
                        state <= axi_xbar_pkg::IDLE;
                    end
                end
                default: state <= axi_xbar_pkg::IDLE;
            endcase
        end
    end

    assign o_grant = grant_q;
    assign o_busy = (state == axi_xbar_pkg::BUSY);

    a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == axi_xbar_pkg::BUSY) |-> $onehot(grant_q));

    a_grant_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == axi_xbar_pkg::IDLE) |-> (grant_q == '0));

    a_grant_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == axi_xbar_pkg::BUSY && !i_done) |=> $stable(grant_q));

endmodule

`default_nettype wire

// File: rtl/axi_xbar_route.sv
`timescale 1ns/10ps
`default_nettype none

module axi_xbar_route #(
    parameter int N_MST = 2,
    parameter int N_SLV = 2
) (
    // Master side
    input  logic [N_MST-1:0]                          i_m_req_valid,
    input  axi_xbar_pkg::xbar_req_t [N_MST-1:0]       i_m_req,
    output logic [N_MST-1:0]                          o_m_req_ready,
    output logic [N_MST-1:0]                          o_m_rsp_valid,
    output axi_xbar_pkg::xbar_rsp_t [N_MST-1:0]       o_m_rsp,
    input  logic [N_MST-1:0]                          i_m_rsp_ready,
    // Slave side
    output logic [N_SLV-1:0]                          o_s_req_valid,
    output axi_xbar_pkg::xbar_req_t [N_SLV-1:0]       o_s_req,
    input  logic [N_SLV-1:0]                          i_s_req_ready,
    input  logic [N_SLV-1:0]                          i_s_rsp_valid,
    input  axi_xbar_pkg::xbar_rsp_t [N_SLV-1:0]       i_s_rsp,
    output logic [N_SLV-1:0]                          o_s_rsp_ready,
    // Decode results
    input  logic [N_MST-1:0][N_SLV-1:0]               i_slv_sel,
    input  logic [N_MST-1:0]                          i_dec_err,
    // Arbiters
    input  logic [N_SLV-1:0][N_MST-1:0]               i_grant,
    output logic [N_SLV-1:0][N_MST-1:0]               o_arb_req,
    output logic [N_SLV-1:0]                          o_arb_done,
    // Error responder slots
    output logic [N_MST-1:0]                          o_err_req_valid,
    input  logic [N_MST-1:0]                          i_err_req_ready,
    input  logic [N_MST-1:0]                          i_err_rsp_valid,
    input  axi_xbar_pkg::xbar_rsp_t [N_MST-1:0]       i_err_rsp,
    output logic [N_MST-1:0]                          o_err_rsp_ready
);

    // Master holds a grant on some slave
    logic [N_MST-1:0] m_granted;

    always_comb begin
        for (int s = 0; s < N_SLV; s++) begin
            for (int m = 0; m < N_MST; m++) begin
                o_arb_req[s][m] = i_m_req_valid[m] & i_slv_sel[m][s];
            end
        end
    end

    // Each slave port driven by its granted master
    always_comb begin
        for (int s = 0; s < N_SLV; s++) begin
            o_s_req_valid[s] = 1'b0;
            o_s_req[s] = '0;
            for (int m = 0; m < N_MST; m++) begin
                if (i_grant[s][m]) begin
                    o_s_req_valid[s] = i_m_req_valid[m];
                    o_s_req[s] = i_m_req[m];
                end
            end
        end
    end

    assign o_err_req_valid = i_m_req_valid & i_dec_err;

    always_comb begin
        for (int m = 0; m < N_MST; m++) begin
            m_granted[m] = 1'b0;
            o_m_req_ready[m] = o_err_req_valid[m] & i_err_req_ready[m];
            for (int s = 0; s < N_SLV; s++) begin
                if (i_grant[s][m]) begin
                    m_granted[m] = 1'b1;
                    o_m_req_ready[m] = i_m_req_valid[m] & i_s_req_ready[s];
                end
            end
        end
    end

    // Error slot answers unless a slave is granted
    always_comb begin
        for (int m = 0; m < N_MST; m++) begin
            o_m_rsp_valid[m] = i_err_rsp_valid[m];
            o_m_rsp[m] = i_err_rsp[m];
            for (int s = 0; s < N_SLV; s++) begin
                if (i_grant[s][m]) begin
                    o_m_rsp_valid[m] = i_s_rsp_valid[s];
                    o_m_rsp[m] = i_s_rsp[s];
                end
            end
        end
    end

    assign o_err_rsp_ready = i_m_rsp_ready & ~m_granted;

    always_comb begin
        for (int s = 0; s < N_SLV; s++) begin
            o_s_rsp_ready[s] = |(i_grant[s] & i_m_rsp_ready);
        end
    end

    // Lock released on the response handshake
    assign o_arb_done = i_s_rsp_valid & o_s_rsp_ready;

endmodule

`default_nettype wire

// File: rtl/axi_decerr_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axi_decerr_slave #(
    parameter int N_MST = 2
) (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic [N_MST-1:0]                    i_req_valid,
    output logic [N_MST-1:0]                    o_req_ready,
    output logic [N_MST-1:0]                    o_rsp_valid,
    output axi_xbar_pkg::xbar_rsp_t [N_MST-1:0] o_rsp,
    input  logic [N_MST-1:0]                    i_rsp_ready
);

    // One response slot per master
    logic [N_MST-1:0] pending;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending <= '0;
        end else begin
            for (int m = 0; m < N_MST; m++) begin
                if (i_req_valid[m] && o_req_ready[m]) begin
                    pending[m] <= 1'b1;
                end else if (pending[m] && i_rsp_ready[m]) begin
                    pending[m] <= 1'b0;
                end
            end
        end
    end

    assign o_req_ready = ~pending;
    assign o_rsp_valid = pending;

    always_comb begin
        for (int m = 0; m < N_MST; m++) begin
            o_rsp[m].rdata = '0;
            o_rsp[m].resp = axi_xbar_pkg::DECERR;
        end
    end

    // Accepted request answers next cycle and blocks the slot meanwhile
    for (genvar m = 0; m < N_MST; m++) begin : g_chk
        a_answer: assert property (@(posedge i_clk) disable iff (i_rst)
            (i_req_valid[m] && o_req_ready[m]) |=> (o_rsp_valid[m] && !o_req_ready[m]));
    end

endmodule

`default_nettype wire

// File: rtl/axi_crossbar.sv
`timescale 1ns/10ps
`default_nettype none

module axi_crossbar #(
    parameter int N_MST = 2,
    parameter int N_SLV = 2,
    parameter logic [N_SLV*axi_xbar_pkg::ADDR_W-1:0] SLV_START = {32'h0001_0000, 32'h0000_0000},
    parameter logic [N_SLV*axi_xbar_pkg::ADDR_W-1:0] SLV_END = {32'h0001_0FFF, 32'h0000_0FFF}
) (
    input  logic                                i_clk,
    input  logic                                i_rst,
    // Master ports
    input  logic [N_MST-1:0]                    i_m_req_valid,
    input  axi_xbar_pkg::xbar_req_t [N_MST-1:0] i_m_req,
    output logic [N_MST-1:0]                    o_m_req_ready,
    output logic [N_MST-1:0]                    o_m_rsp_valid,
    output axi_xbar_pkg::xbar_rsp_t [N_MST-1:0] o_m_rsp,
    input  logic [N_MST-1:0]                    i_m_rsp_ready,
    // Slave ports
    output logic [N_SLV-1:0]                    o_s_req_valid,
    output axi_xbar_pkg::xbar_req_t [N_SLV-1:0] o_s_req,
    input  logic [N_SLV-1:0]                    i_s_req_ready,
    input  logic [N_SLV-1:0]                    i_s_rsp_valid,
    input  axi_xbar_pkg::xbar_rsp_t [N_SLV-1:0] i_s_rsp,
    output logic [N_SLV-1:0]                    o_s_rsp_ready
);

    logic [N_MST-1:0][N_SLV-1:0]         slv_sel;
    logic [N_MST-1:0]                    dec_err;
    logic [N_SLV-1:0][N_MST-1:0]         grant;
    logic [N_SLV-1:0][N_MST-1:0]         arb_req;
    logic [N_SLV-1:0]                    arb_done;
    logic [N_MST-1:0]                    err_req_valid;
    logic [N_MST-1:0]                    err_req_ready;
    logic [N_MST-1:0]                    err_rsp_valid;
    axi_xbar_pkg::xbar_rsp_t [N_MST-1:0] err_rsp;
    logic [N_MST-1:0]                    err_rsp_ready;

    for (genvar m = 0; m < N_MST; m++) begin : g_dec
        axi_addr_decode #(
            .N_SLV     (N_SLV),
            .SLV_START (SLV_START),
            .SLV_END   (SLV_END)
        ) axi_addr_decode_i (
            .i_addr    (i_m_req[m].addr),
            .o_slv_sel (slv_sel[m]),
            .o_dec_err (dec_err[m])
        );
    end

    for (genvar s = 0; s < N_SLV; s++) begin : g_arb
        axi_xbar_arbiter #(
            .N_MST (N_MST)
        ) axi_xbar_arbiter_i (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_req   (arb_req[s]),
            .i_done  (arb_done[s]),
            .o_grant (grant[s]),
            .o_busy  ()
        );
    end

    axi_xbar_route #(
        .N_MST (N_MST),
        .N_SLV (N_SLV)
    ) axi_xbar_route_i (
        .i_m_req_valid   (i_m_req_valid),
        .i_m_req         (i_m_req),
        .o_m_req_ready   (o_m_req_ready),
        .o_m_rsp_valid   (o_m_rsp_valid),
        .o_m_rsp         (o_m_rsp),
        .i_m_rsp_ready   (i_m_rsp_ready),
        .o_s_req_valid   (o_s_req_valid),
        .o_s_req         (o_s_req),
        .i_s_req_ready   (i_s_req_ready),
        .i_s_rsp_valid   (i_s_rsp_valid),
        .i_s_rsp         (i_s_rsp),
        .o_s_rsp_ready   (o_s_rsp_ready),
        .i_slv_sel       (slv_sel),
        .i_dec_err       (dec_err),
        .i_grant         (grant),
        .o_arb_req       (arb_req),
        .o_arb_done      (arb_done),
        .o_err_req_valid (err_req_valid),
        .i_err_req_ready (err_req_ready),
        .i_err_rsp_valid (err_rsp_valid),
        .i_err_rsp       (err_rsp),
        .o_err_rsp_ready (err_rsp_ready)
    );

    axi_decerr_slave #(
        .N_MST (N_MST)
    ) axi_decerr_slave_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (err_req_valid),
        .o_req_ready (err_req_ready),
        .o_rsp_valid (err_rsp_valid),
        .o_rsp       (err_rsp),
        .i_rsp_ready (err_rsp_ready)
    );

endmodule

`default_nettype wire

// File: bench/tb_axi_crossbar.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_crossbar;

    // Far above 16 transactions of under 10 cycles each
    localparam int          CYCLE_LIMIT = 2000;
    localparam logic [31:0] LFSR_SEED = 32'd53;

    logic                          i_clk = 1'b0;
    logic                          i_rst;
    logic [1:0]                    i_m_req_valid;
    axi_xbar_pkg::xbar_req_t [1:0] i_m_req;
    logic [1:0]                    o_m_req_ready;
    logic [1:0]                    o_m_rsp_valid;
    axi_xbar_pkg::xbar_rsp_t [1:0] o_m_rsp;
    logic [1:0]                    i_m_rsp_ready;
    logic [1:0]                    o_s_req_valid;
    axi_xbar_pkg::xbar_req_t [1:0] o_s_req;
    logic [1:0]                    i_s_req_ready;
    logic [1:0]                    i_s_rsp_valid;
    axi_xbar_pkg::xbar_rsp_t [1:0] i_s_rsp;
    logic [1:0]                    o_s_rsp_ready;

    axi_xbar_pkg::data_t     mem [2][256];
    axi_xbar_pkg::xbar_req_t last_wr [2];
    int                      s_req_count [2];
    logic                    s_overlap;
    int                      cycles = 0;
    logic [31:0]             lfsr_state = LFSR_SEED;
    string                   cur_test;
    int                      test_errors;
    int                      run_tests = 0;
    int                      failed_tests = 0;
    int                      failed_checks = 0;
    axi_xbar_pkg::xbar_rsp_t rsp;
    axi_xbar_pkg::data_t     word_a;
    axi_xbar_pkg::data_t     word_b;
    int                      t_a;
    int                      t_b;

    axi_crossbar #(
        .N_MST     (2),
        .N_SLV     (2),
        .SLV_START ({32'h0001_0000, 32'h0000_0000}),
        .SLV_END   ({32'h0001_0FFF, 32'h0000_0FFF})
    ) axi_crossbar_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_m_req_valid (i_m_req_valid),
        .i_m_req       (i_m_req),
        .o_m_req_ready (o_m_req_ready),
        .o_m_rsp_valid (o_m_rsp_valid),
        .o_m_rsp       (o_m_rsp),
        .i_m_rsp_ready (i_m_rsp_ready),
        .o_s_req_valid (o_s_req_valid),
        .o_s_req       (o_s_req),
        .i_s_req_ready (i_s_req_ready),
        .i_s_rsp_valid (i_s_rsp_valid),
        .i_s_rsp       (i_s_rsp),
        .o_s_rsp_ready (o_s_rsp_ready)
    );

    always #4 i_clk = ~i_clk;

    // Memory slaves with 1 wait cycle on port 0 and 3 on port 1
    for (genvar s = 0; s < 2; s++) begin : g_slave
        localparam int WAIT = (s == 0) ? 1 : 3;
        int count;
        always @(posedge i_clk) begin
            logic                    rst_s;
            logic                    take;
            logic                    done;
            axi_xbar_pkg::xbar_req_t req;
            rst_s = i_rst;
            take = o_s_req_valid[s] && i_s_req_ready[s];
            done = i_s_rsp_valid[s] && o_s_rsp_ready[s];
            req = o_s_req[s];
            if (o_s_req_valid[s]) begin
                s_req_count[s]++;
            end
            #1;
            if (rst_s) begin
                i_s_req_ready[s] = 1'b1;
                i_s_rsp_valid[s] = 1'b0;
                count = 0;
            end else if (take) begin
                i_s_req_ready[s] = 1'b0;
                i_s_rsp[s].resp = axi_xbar_pkg::OKAY;
                i_s_rsp[s].rdata = req.write ? '0 : mem[s][req.addr[9:2]];
                if (req.write) begin
                    last_wr[s] = req;
                    for (int b = 0; b < 4; b++) begin
                        if (req.wstrb[b]) begin
                            mem[s][req.addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
                        end
                    end
                end
                count = WAIT;
            end else if (count > 0) begin
                count = count - 1;
                if (count == 0) begin
                    i_s_rsp_valid[s] = 1'b1;
                end
            end else if (done) begin
                i_s_rsp_valid[s] = 1'b0;
                i_s_req_ready[s] = 1'b1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (&o_s_req_valid) begin
            s_overlap <= 1'b1;
        end
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word[b] = lfsr_state[0];
        end
        return word;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
            input logic [31:0] act);
        assert (act === exp)
            else begin
                $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
                test_errors++;
            end
    endtask

    task automatic confirm(input logic cond, input string what);
        assert (cond)
            else begin
                $display("%s: %s", cur_test, what);
                test_errors++;
            end
    endtask

    task begin_test(input string name);
        cur_test = name;
        test_errors = 0;
        s_req_count = '{0, 0};
        s_overlap = 1'b0;
    endtask

    task finish_test();
        if (test_errors == 0) begin
            $display("PASS %s", cur_test);
        end else begin
            $display("FAIL %s with %0d errors", cur_test, test_errors);
            failed_tests++;
            failed_checks += test_errors;
        end
        run_tests++;
    endtask

    task reset_dut();
        i_rst = 1'b1;
        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
    endtask

    // Cycle numbers of the request and response transfers come back in t_req and t_rsp
    task automatic run_access(input int m, input axi_xbar_pkg::addr_t addr, input logic write,
            input axi_xbar_pkg::data_t wdata, input axi_xbar_pkg::strb_t wstrb,
            output axi_xbar_pkg::xbar_rsp_t rsp_o, output int t_req, output int t_rsp);
        i_m_req[m] = '{addr: addr, write: write, wdata: wdata, wstrb: wstrb};
        i_m_req_valid[m] = 1'b1;
        do @(posedge i_clk); while (!o_m_req_ready[m]);
        #1;
        i_m_req_valid[m] = 1'b0;
        t_req = cycles;
        do @(posedge i_clk); while (!o_m_rsp_valid[m]);
        rsp_o = o_m_rsp[m];
        #1;
        t_rsp = cycles;
    endtask

    task automatic write_read(input int m, input axi_xbar_pkg::addr_t addr,
            input axi_xbar_pkg::data_t word, output int t_wr);
        axi_xbar_pkg::xbar_rsp_t r;
        int                      t_rd;
        int                      t_end;
        run_access(m, addr, 1'b1, word, 4'hF, r, t_wr, t_end);
        compare_word($sformatf("master %0d write resp", m), axi_xbar_pkg::OKAY, r.resp);
        run_access(m, addr, 1'b0, '0, 4'h0, r, t_rd, t_end);
        compare_word($sformatf("master %0d read resp", m), axi_xbar_pkg::OKAY, r.resp);
        compare_word($sformatf("master %0d read data", m), word, r.rdata);
    endtask

    task write_read_slave0();
        begin_test("write_read_slave0");
        word_a = random_word();
        write_read(0, 32'h0000_0010, word_a, t_a);
        finish_test();
    endtask

    task write_read_slave1();
        begin_test("write_read_slave1");
        word_a = random_word();
        write_read(1, 32'h0001_0020, word_a, t_a);
        compare_word("slave 1 write addr", 32'h0001_0020, last_wr[1].addr);
        compare_word("slave 1 write data", word_a, last_wr[1].wdata);
        confirm(s_req_count[0] == 0, "slave port 0 saw a valid request");
        finish_test();
    endtask

    task unmapped_read();
        begin_test("unmapped_read");
        run_access(0, 32'h0002_0000, 1'b0, '0, 4'h0, rsp, t_a, t_b);
        compare_word("resp", axi_xbar_pkg::DECERR, rsp.resp);
        compare_word("rdata", 32'h0, rsp.rdata);
        compare_word("response latency", 1, t_b - t_a);
        confirm(s_req_count[0] == 0 && s_req_count[1] == 0,
            "a slave port saw a request for an unmapped address");
        finish_test();
    endtask

    task partial_strobe_write();
        begin_test("partial_strobe_write");
        word_a = 32'h1122_3344;
        word_b = random_word();
        run_access(0, 32'h0000_0040, 1'b1, word_a, 4'hF, rsp, t_a, t_b);
        run_access(0, 32'h0000_0040, 1'b1, word_b, 4'b0011, rsp, t_a, t_b);
        compare_word("write resp", axi_xbar_pkg::OKAY, rsp.resp);
        run_access(0, 32'h0000_0040, 1'b0, '0, 4'h0, rsp, t_a, t_b);
        compare_word("merged read data", {word_a[31:16], word_b[15:0]}, rsp.rdata);
        finish_test();
    endtask

    task contention_same_slave();
        begin_test("contention_same_slave");
        reset_dut();
        word_a = random_word();
        word_b = random_word();
        fork
            write_read(0, 32'h0000_0080, word_a, t_a);
            write_read(1, 32'h0000_0084, word_b, t_b);
        join
        confirm(t_a < t_b, "master 1 was served before master 0");
        finish_test();
    endtask

    task parallel_cross_traffic();
        begin_test("parallel_cross_traffic");
        word_a = random_word();
        word_b = random_word();
        fork
            write_read(0, 32'h0001_0100, word_a, t_a);
            write_read(1, 32'h0000_0100, word_b, t_b);
        join
        confirm(s_overlap, "the requests on the two slave ports never overlapped");
        finish_test();
    endtask

    initial begin
        i_rst = 1'b1;
        i_m_req_valid = '0;
        i_m_req = '0;
        i_m_rsp_ready = '1;
        i_s_req_ready = '0;
        i_s_rsp_valid = '0;
        i_s_rsp = '0;
        // Fill depends on slave and full word index
        for (int i = 0; i < 256; i++) begin
            mem[0][i] = 32'hA000_0000 | (i * 32'h0001_0101);
            mem[1][i] = 32'hB000_0000 | (i * 32'h0001_0101);
        end
        reset_dut();
        write_read_slave0();
        write_read_slave1();
        unmapped_read();
        partial_strobe_write();
        contention_same_slave();
        parallel_cross_traffic();
        $display("Summary: passed %0d of %0d tests, %0d failed checks",
            run_tests - failed_tests, run_tests, failed_checks);
        if (failed_checks == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/axi_xbar_pkg.sv
rtl/axi_addr_decode.sv
rtl/axi_xbar_arbiter.sv
rtl/axi_xbar_route.sv
rtl/axi_decerr_slave.sv
rtl/axi_crossbar.sv
bench/tb_axi_crossbar.sv

// File: Bender.yml
package:
  name: axi_crossbar

sources:
  - rtl/axi_xbar_pkg.sv
  - rtl/axi_addr_decode.sv
  - rtl/axi_xbar_arbiter.sv
  - rtl/axi_xbar_route.sv
  - rtl/axi_decerr_slave.sv
  - rtl/axi_crossbar.sv
  - target: test
    files:
      - bench/tb_axi_crossbar.sv
